// ==== rtl/mp_pkg.sv ====
// Shared sizes, register map, flit field positions and FSM states.
// The design is built and checked at this one size only.
// Flit layout: dest [31:27], class [26:24], src [23:19], rest free.
// Control requests are single-flit packets of class 7 with bit 0 clear.
package mp_pkg;

   // Flit and bus data width
   localparam int DATA_WIDTH = 32;

   // Flits per packet buffer
   localparam int BUF_DEPTH = 16;

   // Packet size must hold BUF_DEPTH itself
   localparam int SIZE_WIDTH = $clog2(BUF_DEPTH + 1);

   // Buffer pointers
   localparam int PTR_WIDTH = $clog2(BUF_DEPTH);

   // Register indexes, taken from bus address bits 5:2
   localparam logic [3:0] REG_FIFO   = 4'd0;
   localparam logic [3:0] REG_STATUS = 4'd1;

   // Flit header fields, each 5 or 3 bits wide
   localparam int CLASS_LSB = 24;
   localparam int DEST_LSB  = 27;
   localparam int SRC_LSB   = 19;
   localparam logic [2:0] CTRL_CLASS = 3'd7;

   // Egress FSM, size word then flits
   typedef enum logic [1:0] {
      out_idle,
      out_first,
      out_payload
   } out_state_e;

   // Ingress FSM, size read then flit reads
   typedef enum logic {
      in_idle,
      in_flit
   } in_state_e;

endpackage

// ==== rtl/mp_packet_buffer.sv ====
// Flit FIFO that only presents whole packets.
// out_size is the flit count of the head packet, valid with out_valid.
// A packet longer than BUF_DEPTH never completes and blocks the buffer.
module mp_packet_buffer (
   input  logic                              clk,
   input  logic                              rst,
   input  logic [mp_pkg::DATA_WIDTH-1:0]     in_flit,
   input  logic                              in_last,
   input  logic                              in_valid,
   output logic                              in_ready,
   output logic [mp_pkg::DATA_WIDTH-1:0]     out_flit,
   output logic                              out_last,
   output logic                              out_valid,
   input  logic                              out_ready,
   output logic [mp_pkg::SIZE_WIDTH:0]       out_size
);

   // Flit store, top bit is the last mark
   logic [mp_pkg::DATA_WIDTH:0]   mem [mp_pkg::BUF_DEPTH];
   logic [mp_pkg::PTR_WIDTH-1:0]  wr_ptr;
   logic [mp_pkg::PTR_WIDTH-1:0]  rd_ptr;
   logic [mp_pkg::PTR_WIDTH:0]    fill;

   // One length entry per stored packet, each packet has at least one flit
   logic [mp_pkg::SIZE_WIDTH-1:0] len_q [mp_pkg::BUF_DEPTH];
   logic [mp_pkg::PTR_WIDTH-1:0]  len_wr_ptr;
   logic [mp_pkg::PTR_WIDTH-1:0]  len_rd_ptr;
   logic [mp_pkg::PTR_WIDTH:0]    pkt_count;

   // Flits taken so far of the packet being written
   logic [mp_pkg::SIZE_WIDTH-1:0] cur_len;

   logic push;
   logic pop;

   assign in_ready  = (fill != (mp_pkg::PTR_WIDTH + 1)'(mp_pkg::BUF_DEPTH));
   assign out_valid = (pkt_count != '0);
   assign push      = in_valid & in_ready;
   assign pop       = out_valid & out_ready;

   assign out_flit = mem[rd_ptr][mp_pkg::DATA_WIDTH-1:0];
   assign out_last = mem[rd_ptr][mp_pkg::DATA_WIDTH];
   assign out_size = {1'b0, len_q[len_rd_ptr]};

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= {in_last, in_flit};
      end
      // Length is known once the last flit arrives
      if (push && in_last) begin
         len_q[len_wr_ptr] <= cur_len + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         fill       <= '0;
         len_wr_ptr <= '0;
         len_rd_ptr <= '0;
         pkt_count  <= '0;
         cur_len    <= '0;
      end else begin
         if (push) begin
            wr_ptr  <= wr_ptr + 1'b1;
            cur_len <= in_last ? '0 : cur_len + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         if (push && !pop) begin
            fill <= fill + 1'b1;
         end else if (pop && !push) begin
            fill <= fill - 1'b1;
         end
         if (push && in_last) begin
            len_wr_ptr <= len_wr_ptr + 1'b1;
         end
         if (pop && out_last) begin
            len_rd_ptr <= len_rd_ptr + 1'b1;
         end
         // Whole packets in, whole packets out
         if ((push && in_last) && !(pop && out_last)) begin
            pkt_count <= pkt_count + 1'b1;
         end else if ((pop && out_last) && !(push && in_last)) begin
            pkt_count <= pkt_count - 1'b1;
         end
      end
   end

endmodule

// ==== rtl/mp_ctrl_responder.sv ====
// Answers control requests from the NoC without software.
// Requests must be single-flit packets; one reply is held at a time and
// ingress stalls until it has gone out.
module mp_ctrl_responder (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          enabled,
   input  logic [mp_pkg::DATA_WIDTH-1:0] noc_in_flit,
   input  logic                          noc_in_last,
   input  logic                          noc_in_valid,
   output logic                          noc_in_ready,
   output logic [mp_pkg::DATA_WIDTH-1:0] ing_flit,
   output logic                          ing_last,
   output logic                          ing_valid,
   input  logic                          ing_ready,
   input  logic [mp_pkg::DATA_WIDTH-1:0] eg_flit,
   input  logic                          eg_last,
   input  logic                          eg_valid,
   output logic                          eg_ready,
   output logic [mp_pkg::DATA_WIDTH-1:0] noc_out_flit,
   output logic                          noc_out_last,
   output logic                          noc_out_valid,
   input  logic                          noc_out_ready
);

   logic                          in_first;
   logic                          is_req;
   logic                          pending;
   logic [mp_pkg::DATA_WIDTH-1:0] reply_flit;
   logic [mp_pkg::DATA_WIDTH-1:0] reply_nxt;
   logic                          eg_mid;
   logic                          eg_hold;
   logic                          sel_reply;

   // Request is the first flit of a packet with control class, bit 0 clear
   assign is_req = noc_in_valid & in_first & ~noc_in_flit[0] &
                   (noc_in_flit[mp_pkg::CLASS_LSB +: 3] == mp_pkg::CTRL_CLASS);

   // Swallowed requests never reach the ingress buffer
   assign noc_in_ready = ~pending & (is_req | ing_ready);
   assign ing_valid    = noc_in_valid & ~pending & ~is_req;
   assign ing_flit     = noc_in_flit;
   assign ing_last     = noc_in_last;

   // Reply swaps source and destination, reports enable in bit 1
   always_comb begin
      reply_nxt = noc_in_flit;
      reply_nxt[mp_pkg::DEST_LSB +: 5] = noc_in_flit[mp_pkg::SRC_LSB +: 5];
      reply_nxt[mp_pkg::SRC_LSB +: 5]  = noc_in_flit[mp_pkg::DEST_LSB +: 5];
      reply_nxt[1] = enabled;
      reply_nxt[0] = 1'b1;
   end

   // Reply only between egress packets, and never replaces a stalled flit
   assign sel_reply     = pending & ~eg_mid & ~eg_hold;
   assign noc_out_flit  = sel_reply ? reply_flit : eg_flit;
   assign noc_out_last  = sel_reply | eg_last;
   assign noc_out_valid = sel_reply | eg_valid;
   assign eg_ready      = ~sel_reply & noc_out_ready;

   always_ff @(posedge clk) begin
      if (is_req && !pending) begin
         reply_flit <= reply_nxt;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         in_first <= 1'b1;
         pending  <= 1'b0;
         eg_mid   <= 1'b0;
         eg_hold  <= 1'b0;
      end else begin
         if (noc_in_valid && noc_in_ready) begin
            in_first <= noc_in_last;
         end
         if (is_req && !pending) begin
            pending <= 1'b1;
         end else if (sel_reply && noc_out_ready) begin
            pending <= 1'b0;
         end
         if (eg_valid && eg_ready) begin
            eg_mid <= ~eg_last;
         end
         // Egress flit offered but not taken keeps the link
         eg_hold <= eg_valid & ~sel_reply & ~noc_out_ready;
      end
   end

endmodule

// ==== rtl/mp_endpoint.sv ====
// Software message endpoint with a plain strobe bus port.
// Register 0 moves sizes and flits, register 1 is enable and status.
// Bus outputs are combinational; the master holds its request until
// ack or err. A size of zero is acked and ignored.
module mp_endpoint (
   input  logic                          clk,
   input  logic                          rst,
   input  logic [mp_pkg::DATA_WIDTH-1:0] bus_addr,
   input  logic                          bus_we,
   input  logic                          bus_en,
   input  logic [mp_pkg::DATA_WIDTH-1:0] bus_wdata,
   output logic [mp_pkg::DATA_WIDTH-1:0] bus_rdata,
   output logic                          bus_ack,
   output logic                          bus_err,
   output logic                          irq,
   output logic [mp_pkg::DATA_WIDTH-1:0] noc_out_flit,
   output logic                          noc_out_last,
   output logic                          noc_out_valid,
   input  logic                          noc_out_ready,
   input  logic [mp_pkg::DATA_WIDTH-1:0] noc_in_flit,
   input  logic                          noc_in_last,
   input  logic                          noc_in_valid,
   output logic                          noc_in_ready
);

   logic [3:0]                    reg_idx;
   logic                          enabled;
   logic                          set_enable;
   logic                          fifo_rd;
   logic                          fifo_wr;
   logic                          rd_ack;
   logic                          wr_ack;
   logic [mp_pkg::DATA_WIDTH-1:0] rd_data;

   mp_pkg::out_state_e            out_state;
   mp_pkg::out_state_e            out_state_nxt;
   logic [mp_pkg::SIZE_WIDTH-1:0] size_cnt;
   logic [mp_pkg::SIZE_WIDTH-1:0] size_cnt_nxt;
   logic                          tx_last;
   logic                          tx_valid;
   logic                          tx_ready;

   mp_pkg::in_state_e             in_state;
   mp_pkg::in_state_e             in_state_nxt;
   logic [mp_pkg::DATA_WIDTH-1:0] rx_flit;
   logic                          rx_last;
   logic                          rx_valid;
   logic                          rx_pop;
   logic [mp_pkg::SIZE_WIDTH:0]   rx_size;

   // Between responder and the two buffers
   logic [mp_pkg::DATA_WIDTH-1:0] ing_flit;
   logic                          ing_last;
   logic                          ing_valid;
   logic                          ing_ready;
   logic [mp_pkg::DATA_WIDTH-1:0] eg_flit;
   logic                          eg_last;
   logic                          eg_valid;
   logic                          eg_ready;

   assign reg_idx = bus_addr[5:2];
   assign irq     = rx_valid;

   // Register decode
   always_comb begin
      bus_ack    = 1'b0;
      bus_err    = 1'b0;
      bus_rdata  = '0;
      set_enable = 1'b0;
      fifo_rd    = 1'b0;
      fifo_wr    = 1'b0;
      if (bus_en) begin
         if (reg_idx == mp_pkg::REG_FIFO) begin
            if (bus_we) begin
               fifo_wr = 1'b1;
               bus_ack = wr_ack;
            end else begin
               fifo_rd   = 1'b1;
               bus_ack   = rd_ack;
               bus_rdata = rd_data;
            end
         end else if (reg_idx == mp_pkg::REG_STATUS) begin
            bus_ack = 1'b1;
            if (bus_we) begin
               set_enable = 1'b1;
            end else begin
               // Bit 1 egress link busy, bit 0 packet waiting
               bus_rdata = {{(mp_pkg::DATA_WIDTH - 2){1'b0}}, noc_out_valid, rx_valid};
            end
         end else begin
            bus_err = 1'b1;
         end
      end
   end

   // Egress FSM, size first, then count flits down to the last
   always_comb begin
      out_state_nxt = out_state;
      size_cnt_nxt  = size_cnt;
      wr_ack        = 1'b0;
      tx_valid      = 1'b0;
      tx_last       = (size_cnt == 1);
      case (out_state)
         mp_pkg::out_idle: begin
            if (fifo_wr) begin
               wr_ack       = 1'b1;
               size_cnt_nxt = bus_wdata[mp_pkg::SIZE_WIDTH-1:0];
               if (bus_wdata[mp_pkg::SIZE_WIDTH-1:0] != '0) begin
                  out_state_nxt = mp_pkg::out_first;
               end
            end
         end
         mp_pkg::out_first, mp_pkg::out_payload: begin
            if (fifo_wr) begin
               tx_valid = 1'b1;
               // Full buffer stretches the bus write
               if (tx_ready) begin
                  wr_ack        = 1'b1;
                  size_cnt_nxt  = size_cnt - 1'b1;
                  out_state_nxt = tx_last ? mp_pkg::out_idle : mp_pkg::out_payload;
               end
            end
         end
         default: out_state_nxt = mp_pkg::out_idle;
      endcase
   end

   // Ingress FSM, size read, then one pop per read up to the last flit
   always_comb begin
      in_state_nxt = in_state;
      rd_ack       = 1'b0;
      rd_data      = '0;
      rx_pop       = 1'b0;
      case (in_state)
         mp_pkg::in_idle: begin
            if (fifo_rd) begin
               rd_ack = 1'b1;
               if (rx_valid) begin
                  rd_data = {{(mp_pkg::DATA_WIDTH - mp_pkg::SIZE_WIDTH - 1){1'b0}}, rx_size};
                  if (rx_size != '0) begin
                     in_state_nxt = mp_pkg::in_flit;
                  end
               end
            end
         end
         mp_pkg::in_flit: begin
            // Whole packet is stored, so a flit is always there
            if (fifo_rd) begin
               rd_ack  = 1'b1;
               rd_data = rx_flit;
               rx_pop  = 1'b1;
               if (rx_last) begin
                  in_state_nxt = mp_pkg::in_idle;
               end
            end
         end
         default: in_state_nxt = mp_pkg::in_idle;
      endcase
   end

   always_ff @(posedge clk) begin
      size_cnt <= size_cnt_nxt;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         out_state <= mp_pkg::out_idle;
         in_state  <= mp_pkg::in_idle;
         enabled   <= 1'b0;
      end else begin
         out_state <= out_state_nxt;
         in_state  <= in_state_nxt;
         if (set_enable) begin
            enabled <= 1'b1;
         end
      end
   end

   mp_packet_buffer egress_buf_i (
      .clk       (clk),
      .rst       (rst),
      .in_flit   (bus_wdata),
      .in_last   (tx_last),
      .in_valid  (tx_valid),
      .in_ready  (tx_ready),
      .out_flit  (eg_flit),
      .out_last  (eg_last),
      .out_valid (eg_valid),
      .out_ready (eg_ready),
      .out_size  ()
   );

   mp_packet_buffer ingress_buf_i (
      .clk       (clk),
      .rst       (rst),
      .in_flit   (ing_flit),
      .in_last   (ing_last),
      .in_valid  (ing_valid),
      .in_ready  (ing_ready),
      .out_flit  (rx_flit),
      .out_last  (rx_last),
      .out_valid (rx_valid),
      .out_ready (rx_pop),
      .out_size  (rx_size)
   );

   mp_ctrl_responder responder_i (
      .clk           (clk),
      .rst           (rst),
      .enabled       (enabled),
      .noc_in_flit   (noc_in_flit),
      .noc_in_last   (noc_in_last),
      .noc_in_valid  (noc_in_valid),
      .noc_in_ready  (noc_in_ready),
      .ing_flit      (ing_flit),
      .ing_last      (ing_last),
      .ing_valid     (ing_valid),
      .ing_ready     (ing_ready),
      .eg_flit       (eg_flit),
      .eg_last       (eg_last),
      .eg_valid      (eg_valid),
      .eg_ready      (eg_ready),
      .noc_out_flit  (noc_out_flit),
      .noc_out_last  (noc_out_last),
      .noc_out_valid (noc_out_valid),
      .noc_out_ready (noc_out_ready)
   );

endmodule

// ==== rtl/mp_pair_top.sv ====
// Two endpoints joined back to back, each egress feeds the other ingress.
// No routing; every packet sent by one side lands at the other.
module mp_pair_top (
   input  logic                          clk,
   input  logic                          rst,
   input  logic [mp_pkg::DATA_WIDTH-1:0] a_bus_addr,
   input  logic                          a_bus_we,
   input  logic                          a_bus_en,
   input  logic [mp_pkg::DATA_WIDTH-1:0] a_bus_wdata,
   output logic [mp_pkg::DATA_WIDTH-1:0] a_bus_rdata,
   output logic                          a_bus_ack,
   output logic                          a_bus_err,
   output logic                          a_irq,
   input  logic [mp_pkg::DATA_WIDTH-1:0] b_bus_addr,
   input  logic                          b_bus_we,
   input  logic                          b_bus_en,
   input  logic [mp_pkg::DATA_WIDTH-1:0] b_bus_wdata,
   output logic [mp_pkg::DATA_WIDTH-1:0] b_bus_rdata,
   output logic                          b_bus_ack,
   output logic                          b_bus_err,
   output logic                          b_irq
);

   // Link from A to B
   logic [mp_pkg::DATA_WIDTH-1:0] ab_flit;
   logic                          ab_last;
   logic                          ab_valid;
   logic                          ab_ready;

   // Link from B to A
   logic [mp_pkg::DATA_WIDTH-1:0] ba_flit;
   logic                          ba_last;
   logic                          ba_valid;
   logic                          ba_ready;

   mp_endpoint ep_a (
      .clk           (clk),
      .rst           (rst),
      .bus_addr      (a_bus_addr),
      .bus_we        (a_bus_we),
      .bus_en        (a_bus_en),
      .bus_wdata     (a_bus_wdata),
      .bus_rdata     (a_bus_rdata),
      .bus_ack       (a_bus_ack),
      .bus_err       (a_bus_err),
      .irq           (a_irq),
      .noc_out_flit  (ab_flit),
      .noc_out_last  (ab_last),
      .noc_out_valid (ab_valid),
      .noc_out_ready (ab_ready),
      .noc_in_flit   (ba_flit),
      .noc_in_last   (ba_last),
      .noc_in_valid  (ba_valid),
      .noc_in_ready  (ba_ready)
   );

   mp_endpoint ep_b (
      .clk           (clk),
      .rst           (rst),
      .bus_addr      (b_bus_addr),
      .bus_we        (b_bus_we),
      .bus_en        (b_bus_en),
      .bus_wdata     (b_bus_wdata),
      .bus_rdata     (b_bus_rdata),
      .bus_ack       (b_bus_ack),
      .bus_err       (b_bus_err),
      .irq           (b_irq),
      .noc_out_flit  (ba_flit),
      .noc_out_last  (ba_last),
      .noc_out_valid (ba_valid),
      .noc_out_ready (ba_ready),
      .noc_in_flit   (ab_flit),
      .noc_in_last   (ab_last),
      .noc_in_valid  (ab_valid),
      .noc_in_ready  (ab_ready)
   );

endmodule

// ==== verif/mp_checker.sv ====
// Protocol assertions for one endpoint, bound into every mp_endpoint.
// Covers the egress link hold rules and the bus response strobes.
// All properties are disabled while rst is high.
module mp_checker (
   input logic                          clk,
   input logic                          rst,
   input logic [mp_pkg::DATA_WIDTH-1:0] noc_out_flit,
   input logic                          noc_out_last,
   input logic                          noc_out_valid,
   input logic                          noc_out_ready,
   input logic                          bus_ack,
   input logic                          bus_err
);

   int fail_count = 0;

   // Offered flit stays offered until taken
   valid_held_a: assert property (@(posedge clk) disable iff (rst)
      noc_out_valid && !noc_out_ready |=> noc_out_valid)
      else begin
         fail_count++;
         $error("noc_out_valid dropped while waiting for noc_out_ready");
      end

   // Stalled flit and last mark do not change
   flit_stable_a: assert property (@(posedge clk) disable iff (rst)
      noc_out_valid && !noc_out_ready |=> $stable(noc_out_flit) && $stable(noc_out_last))
      else begin
         fail_count++;
         $error("noc_out_flit or noc_out_last changed during a stall");
      end

   // One response kind per bus cycle
   ack_err_a: assert property (@(posedge clk) disable iff (rst)
      !(bus_ack && bus_err))
      else begin
         fail_count++;
         $error("bus_ack and bus_err high together");
      end

endmodule

bind mp_endpoint mp_checker checker_i (
   .clk           (clk),
   .rst           (rst),
   .noc_out_flit  (noc_out_flit),
   .noc_out_last  (noc_out_last),
   .noc_out_valid (noc_out_valid),
   .noc_out_ready (noc_out_ready),
   .bus_ack       (bus_ack),
   .bus_err       (bus_err)
);

// ==== verif/mp_tb.sv ====
// Directed testbench for the two-endpoint pair.
// Port A sends data packets to B; control requests go from A and are
// answered by B's responder. Outputs are sampled on the falling edge.
// Watchdog limit scales with the number of bus accesses and irq waits.
module mp_tb;

   // Longest stretch of one bus access, in cycles
   localparam int BUS_WAIT = 40;
   // Longest wait for an irq to rise
   localparam int IRQ_WAIT = 200;
   // Bus accesses and irq waits over all tests
   localparam int NUM_ACCESSES  = 76;
   localparam int NUM_IRQ_WAITS = 7;
   localparam int MARGIN        = 2;
   localparam int WATCHDOG_CYCLES =
      MARGIN * (NUM_ACCESSES * (BUS_WAIT + 2) + NUM_IRQ_WAITS * IRQ_WAIT);

   logic                          clk;
   logic                          rst;
   logic [mp_pkg::DATA_WIDTH-1:0] a_bus_addr;
   logic                          a_bus_we;
   logic                          a_bus_en;
   logic [mp_pkg::DATA_WIDTH-1:0] a_bus_wdata;
   logic [mp_pkg::DATA_WIDTH-1:0] a_bus_rdata;
   logic                          a_bus_ack;
   logic                          a_bus_err;
   logic                          a_irq;
   logic [mp_pkg::DATA_WIDTH-1:0] b_bus_addr;
   logic                          b_bus_we;
   logic                          b_bus_en;
   logic [mp_pkg::DATA_WIDTH-1:0] b_bus_wdata;
   logic [mp_pkg::DATA_WIDTH-1:0] b_bus_rdata;
   logic                          b_bus_ack;
   logic                          b_bus_err;
   logic                          b_irq;

   int                            value_errors;
   int                            other_errors;
   int                            assert_errors;
   integer                        seed;
   // Flits sent from A, in order, not yet read at B
   logic [mp_pkg::DATA_WIDTH-1:0] sent_q [$];
   logic                          watch_b_irq;
   int                            b_irq_hits;

   mp_pair_top dut_i (
      .clk         (clk),
      .rst         (rst),
      .a_bus_addr  (a_bus_addr),
      .a_bus_we    (a_bus_we),
      .a_bus_en    (a_bus_en),
      .a_bus_wdata (a_bus_wdata),
      .a_bus_rdata (a_bus_rdata),
      .a_bus_ack   (a_bus_ack),
      .a_bus_err   (a_bus_err),
      .a_irq       (a_irq),
      .b_bus_addr  (b_bus_addr),
      .b_bus_we    (b_bus_we),
      .b_bus_en    (b_bus_en),
      .b_bus_wdata (b_bus_wdata),
      .b_bus_rdata (b_bus_rdata),
      .b_bus_ack   (b_bus_ack),
      .b_bus_err   (b_bus_err),
      .b_irq       (b_irq)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // B must stay quiet while a control request is in flight
   always @(negedge clk) begin
      if (watch_b_irq && b_irq) begin
         b_irq_hits <= b_irq_hits + 1;
      end
   end

   function automatic string port_name(input logic side);
      return side ? "B" : "A";
   endfunction

   // Side 0 is port A, side 1 is port B
   task automatic drive_bus(input logic side, input logic en, input logic [3:0] idx,
                            input logic we, input logic [mp_pkg::DATA_WIDTH-1:0] wdata);
      logic [mp_pkg::DATA_WIDTH-1:0] addr;
      addr = {{(mp_pkg::DATA_WIDTH - 6){1'b0}}, idx, 2'b00};
      if (side == 1'b0) begin
         a_bus_en    <= en;
         a_bus_addr  <= addr;
         a_bus_we    <= we;
         a_bus_wdata <= wdata;
      end else begin
         b_bus_en    <= en;
         b_bus_addr  <= addr;
         b_bus_we    <= we;
         b_bus_wdata <= wdata;
      end
   endtask

   // Request held until a falling edge shows ack or err
   task automatic bus_access(input logic side, input logic [3:0] idx, input logic we,
                             input logic [mp_pkg::DATA_WIDTH-1:0] wdata,
                             output logic [mp_pkg::DATA_WIDTH-1:0] rdata,
                             output logic ack, output logic err);
      int waited;
      waited = 0;
      ack    = 1'b0;
      err    = 1'b0;
      rdata  = '0;
      @(posedge clk);
      drive_bus(side, 1'b1, idx, we, wdata);
      while (!ack && !err && waited < BUS_WAIT) begin
         @(negedge clk);
         waited++;
         ack   = side ? b_bus_ack : a_bus_ack;
         err   = side ? b_bus_err : a_bus_err;
         rdata = side ? b_bus_rdata : a_bus_rdata;
      end
      if (!ack && !err) begin
         other_errors++;
         $display("Bus access on port %s index %0d got neither ack nor err",
                  port_name(side), idx);
      end
      // Access completes on this edge
      @(posedge clk);
      drive_bus(side, 1'b0, 4'd0, 1'b0, '0);
   endtask

   task automatic bus_write(input logic side, input logic [3:0] idx,
                            input logic [mp_pkg::DATA_WIDTH-1:0] data,
                            output logic ack, output logic err);
      logic [mp_pkg::DATA_WIDTH-1:0] unused;
      bus_access(side, idx, 1'b1, data, unused, ack, err);
   endtask

   task automatic bus_read(input logic side, input logic [3:0] idx,
                           output logic [mp_pkg::DATA_WIDTH-1:0] data,
                           output logic ack, output logic err);
      bus_access(side, idx, 1'b0, '0, data, ack, err);
   endtask

   task automatic wait_irq(input logic side, input string name);
      int   waited;
      logic seen;
      waited = 0;
      seen   = 1'b0;
      while (!seen && waited < IRQ_WAIT) begin
         @(negedge clk);
         waited++;
         seen = side ? b_irq : a_irq;
      end
      if (!seen) begin
         other_errors++;
         $display("Timeout in %s: irq of port %s never rose", name, port_name(side));
      end
   endtask

   task automatic check_data(input string name, input logic [mp_pkg::DATA_WIDTH-1:0] expected,
                             input logic [mp_pkg::DATA_WIDTH-1:0] actual);
      if (expected !== actual) begin
         value_errors++;
         $display("Error %s: expected %h, actual %h", name, expected, actual);
      end
   endtask

   task automatic check_size(input string name, input logic [mp_pkg::SIZE_WIDTH:0] expected,
                             input logic [mp_pkg::SIZE_WIDTH:0] actual);
      if (expected !== actual) begin
         value_errors++;
         $display("Error %s: expected %0d, actual %0d", name, expected, actual);
      end
   endtask

   task automatic check_bit(input string name, input logic expected, input logic actual);
      if (expected !== actual) begin
         value_errors++;
         $display("Error %s: expected %b, actual %b", name, expected, actual);
      end
   endtask

   // Size word, then n random flits; first flit kept clear of the request pattern
   task automatic send_packet(input logic side, input int n, input string name);
      logic [mp_pkg::DATA_WIDTH-1:0] flit;
      logic                          ack;
      logic                          err;
      bus_write(side, mp_pkg::REG_FIFO, n, ack, err);
      check_bit({name, " size ack"}, 1'b1, ack);
      for (int i = 0; i < n; i++) begin
         flit = $random(seed);
         if (i == 0) begin
            flit[0] = 1'b1;
         end
         sent_q.push_back(flit);
         bus_write(side, mp_pkg::REG_FIFO, flit, ack, err);
         check_bit({name, " flit ack"}, 1'b1, ack);
      end
   endtask

   task automatic recv_packet(input logic side, input int n, input string name);
      logic [mp_pkg::DATA_WIDTH-1:0] data;
      logic [mp_pkg::DATA_WIDTH-1:0] expected;
      logic                          ack;
      logic                          err;
      wait_irq(side, name);
      // Packet waiting in bit 0, nothing offered on this side's egress link
      bus_read(side, mp_pkg::REG_STATUS, data, ack, err);
      check_data({name, " status"}, 32'h0000_0001, data);
      bus_read(side, mp_pkg::REG_FIFO, data, ack, err);
      check_size({name, " size"}, (mp_pkg::SIZE_WIDTH + 1)'(n), data[mp_pkg::SIZE_WIDTH:0]);
      for (int i = 0; i < n; i++) begin
         bus_read(side, mp_pkg::REG_FIFO, data, ack, err);
         expected = sent_q.pop_front();
         check_data({name, " flit"}, expected, data);
      end
   endtask

   task automatic test_reset_regs();
      logic [mp_pkg::DATA_WIDTH-1:0] data;
      logic                          ack;
      logic                          err;
      @(negedge clk);
      check_bit("reset A irq", 1'b0, a_irq);
      check_bit("reset B irq", 1'b0, b_irq);
      bus_read(1'b0, mp_pkg::REG_STATUS, data, ack, err);
      check_data("reset A status", '0, data);
      bus_read(1'b1, mp_pkg::REG_STATUS, data, ack, err);
      check_data("reset B status", '0, data);
      // Enabling A leaves B's reply bit untouched
      bus_write(1'b0, mp_pkg::REG_STATUS, 32'd1, ack, err);
      check_bit("enable A ack", 1'b1, ack);
      bus_read(1'b0, 4'd2, data, ack, err);
      check_bit("index 2 err", 1'b1, err);
      check_bit("index 2 ack", 1'b0, ack);
      bus_read(1'b1, 4'd15, data, ack, err);
      check_bit("index 15 err B", 1'b1, err);
      check_bit("index 15 ack B", 1'b0, ack);
   endtask

   task automatic test_empty_read();
      logic [mp_pkg::DATA_WIDTH-1:0] data;
      logic                          ack;
      logic                          err;
      bus_read(1'b1, mp_pkg::REG_FIFO, data, ack, err);
      check_bit("empty read ack", 1'b1, ack);
      check_data("empty read B", '0, data);
   endtask

   task automatic test_transfer();
      send_packet(1'b0, 1, "transfer p1");
      send_packet(1'b0, 4, "transfer p2");
      recv_packet(1'b1, 1, "transfer p1");
      recv_packet(1'b1, 4, "transfer p2");
      @(negedge clk);
      check_bit("transfer B irq low", 1'b0, b_irq);
   endtask

   // 18 flits overrun B's ingress, so the link stalls until B reads
   task automatic test_queued();
      send_packet(1'b0, 6, "queued p1");
      send_packet(1'b0, 7, "queued p2");
      send_packet(1'b0, 5, "queued p3");
      recv_packet(1'b1, 6, "queued p1");
      recv_packet(1'b1, 7, "queued p2");
      recv_packet(1'b1, 5, "queued p3");
      @(negedge clk);
      check_bit("queued B irq low", 1'b0, b_irq);
   endtask

   task automatic test_ctrl_reply(input logic b_enabled, input string name);
      logic [mp_pkg::DATA_WIDTH-1:0] req;
      logic [mp_pkg::DATA_WIDTH-1:0] expected;
      logic [mp_pkg::DATA_WIDTH-1:0] data;
      logic                          ack;
      logic                          err;
      // Request with bit 1 set, so a disabled reply must clear it
      req = 32'h0000_5a02;
      req[mp_pkg::DEST_LSB +: 5]  = 5'h0b;
      req[mp_pkg::SRC_LSB +: 5]   = 5'h15;
      req[mp_pkg::CLASS_LSB +: 3] = mp_pkg::CTRL_CLASS;
      expected = req;
      expected[mp_pkg::DEST_LSB +: 5] = 5'h15;
      expected[mp_pkg::SRC_LSB +: 5]  = 5'h0b;
      expected[1] = b_enabled;
      expected[0] = 1'b1;
      b_irq_hits  = 0;
      watch_b_irq = 1'b1;
      bus_write(1'b0, mp_pkg::REG_FIFO, 32'd1, ack, err);
      check_bit({name, " size ack"}, 1'b1, ack);
      bus_write(1'b0, mp_pkg::REG_FIFO, req, ack, err);
      check_bit({name, " request ack"}, 1'b1, ack);
      wait_irq(1'b0, name);
      bus_read(1'b0, mp_pkg::REG_FIFO, data, ack, err);
      check_size({name, " size"}, 1, data[mp_pkg::SIZE_WIDTH:0]);
      bus_read(1'b0, mp_pkg::REG_FIFO, data, ack, err);
      check_data({name, " reply"}, expected, data);
      @(negedge clk);
      check_bit({name, " A irq low"}, 1'b0, a_irq);
      watch_b_irq = 1'b0;
      check_bit({name, " B irq quiet"}, 1'b0, b_irq_hits != 0);
   endtask

   initial begin
      logic ack;
      logic err;
      int   total;
      rst         = 1'b1;
      a_bus_addr  = '0;
      a_bus_we    = 1'b0;
      a_bus_en    = 1'b0;
      a_bus_wdata = '0;
      b_bus_addr  = '0;
      b_bus_we    = 1'b0;
      b_bus_en    = 1'b0;
      b_bus_wdata = '0;
      value_errors = 0;
      other_errors = 0;
      watch_b_irq  = 1'b0;
      b_irq_hits   = 0;
      seed         = 32'hd63;
      repeat (2) @(posedge clk);
      rst <= 1'b0;

      test_reset_regs();
      test_empty_read();
      test_transfer();
      test_queued();
      test_ctrl_reply(1'b0, "reply B disabled");
      bus_write(1'b1, mp_pkg::REG_STATUS, 32'd1, ack, err);
      check_bit("enable B ack", 1'b1, ack);
      test_ctrl_reply(1'b1, "reply B enabled");

      assert_errors = dut_i.ep_a.checker_i.fail_count + dut_i.ep_b.checker_i.fail_count;
      total = value_errors + other_errors + assert_errors;
      $display("Errors: %0d value mismatches, %0d protocol failures, %0d assertion failures",
               value_errors, other_errors, assert_errors);
      if (total == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

   // Ends a hung run
   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
      $display("STATUS: FAIL");
      $finish;
   end

endmodule

// ==== build.f ====
rtl/mp_pkg.sv
rtl/mp_packet_buffer.sv
rtl/mp_ctrl_responder.sv
rtl/mp_endpoint.sv
rtl/mp_pair_top.sv
verif/mp_checker.sv
verif/mp_tb.sv
